// File: src/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

`define DEC_INSTR_W 32
`define DEC_REG_W   5

// field positions inside an instruction word
`define DEC_OP_HI    31
`define DEC_OP_LO    26
`define DEC_RS_HI    25
`define DEC_RS_LO    21
`define DEC_RT_HI    20
`define DEC_RT_LO    16
`define DEC_RD_HI    15
`define DEC_RD_LO    11
`define DEC_SHAMT_HI 10
`define DEC_SHAMT_LO 6
`define DEC_FUNCT_HI 5
`define DEC_FUNCT_LO 0
`define DEC_IMM_HI   15
`define DEC_IMM_LO   0
`define DEC_MFMC0_SC 5 // set for ei, clear for di

`endif

// File: src/signals_pkg.sv
`include "decode_config.svh"

package signals_pkg;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_ADDIU   = 6'h09,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_COP0    = 6'h10
  } opcode_e;

  typedef enum logic [5:0] {
    FN_JR   = 6'h08,
    FN_ERET = 6'h18, // co group
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [4:0] {
    RS_MFC0  = 5'h00,
    RS_MTC0  = 5'h04,
    RS_MFMC0 = 5'h0b,
    RS_CO    = 5'h10 // whole group is rs[4] set
  } cop0_rs_e;

  typedef struct packed {
    logic [5:0]            op;
    logic [`DEC_REG_W-1:0] rs;
    logic [`DEC_REG_W-1:0] rt;
    logic [`DEC_REG_W-1:0] rd;
    logic [4:0]            shamt;
    logic [5:0]            funct;
    logic [15:0]           imm16;
  } unpack_t;

  typedef enum logic [1:0] {OPD_NONE, OPD_RS, OPD_RT, OPD_RS_RT} operand_use_e;

  typedef enum logic [2:0] {
    PC_SEQ, PC_BRANCH, PC_JUMP, PC_JR, PC_ERET, PC_EXCEPTION
  } pc_src_e;

  typedef enum logic [1:0] {
    C0_SRC_RT, C0_SRC_STATUS_EI, C0_SRC_STATUS_DI, C0_SRC_STATUS_ERET
  } cop0_src_e;

  typedef enum logic [1:0] {DEST_C0_NONE, DEST_C0_RDSEL, DEST_C0_STATUS} dest_cop0_e;
  typedef enum logic [1:0] {REG_SRC_ALU, REG_SRC_COP0, REG_SRC_IMM_UPPER} reg_src_e;
  typedef enum logic       {REG_DEST_RD, REG_DEST_RT} reg_dest_e;
  typedef enum logic       {EXC_NONE, EXC_RESERVED} exc_chk_e;
  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_e;

  typedef struct packed {
    operand_use_e          opd_use;
    pc_src_e               pc_src;
    cop0_src_e             cop0_src;
    dest_cop0_e            dest_cop0;
    reg_src_e              reg_src;
    reg_dest_e             reg_dest;
    exc_chk_e              exc_chk;
    alu_op_e               alu_op;
    logic                  write_reg;
    logic                  write_cop0;
    logic                  imm_signed;
    logic [`DEC_REG_W-1:0] cop0_sel;
  } control_t;

  // no writes, sequential pc
  function automatic control_t default_control();
    control_t c;
    c.opd_use    = OPD_NONE;
    c.pc_src     = PC_SEQ;
    c.cop0_src   = C0_SRC_RT;
    c.dest_cop0  = DEST_C0_NONE;
    c.reg_src    = REG_SRC_ALU;
    c.reg_dest   = REG_DEST_RD;
    c.exc_chk    = EXC_NONE;
    c.alu_op     = ALU_ADD;
    c.write_reg  = 1'b0;
    c.write_cop0 = 1'b0;
    c.imm_signed = 1'b0;
    c.cop0_sel   = '0;
    return c;
  endfunction

  function automatic control_t reserved_control();
    control_t c;
    c         = default_control();
    c.pc_src  = PC_EXCEPTION;
    c.exc_chk = EXC_RESERVED;
    return c;
  endfunction

  function automatic unpack_t unpack(input logic [`DEC_INSTR_W-1:0] instr);
    unpack_t u;
    u.op    = instr[`DEC_OP_HI:`DEC_OP_LO];
    u.rs    = instr[`DEC_RS_HI:`DEC_RS_LO];
    u.rt    = instr[`DEC_RT_HI:`DEC_RT_LO];
    u.rd    = instr[`DEC_RD_HI:`DEC_RD_LO];
    u.shamt = instr[`DEC_SHAMT_HI:`DEC_SHAMT_LO];
    u.funct = instr[`DEC_FUNCT_HI:`DEC_FUNCT_LO];
    u.imm16 = instr[`DEC_IMM_HI:`DEC_IMM_LO];
    return u;
  endfunction

endpackage

// File: src/cop0_decoder.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module cop0_decoder (
  input  logic [`DEC_INSTR_W-1:0] instr,
  output signals_pkg::control_t   ctl
);

  signals_pkg::unpack_t f;

  assign f = signals_pkg::unpack(instr);

  always_comb begin
    ctl = signals_pkg::default_control();
    case (f.rs)
      signals_pkg::RS_MTC0: begin
        ctl.opd_use    = signals_pkg::OPD_RT;
        ctl.cop0_src   = signals_pkg::C0_SRC_RT;
        ctl.dest_cop0  = signals_pkg::DEST_C0_RDSEL;
        ctl.write_cop0 = 1'b1;
        ctl.cop0_sel   = f.rd;
      end

      signals_pkg::RS_MFC0: begin
        ctl.reg_src   = signals_pkg::REG_SRC_COP0;
        ctl.reg_dest  = signals_pkg::REG_DEST_RT;
        ctl.write_reg = 1'b1;
        ctl.cop0_sel  = f.rd; // register being read
      end

      signals_pkg::RS_MFMC0: begin
        if (instr[`DEC_MFMC0_SC]) begin
          ctl.cop0_src = signals_pkg::C0_SRC_STATUS_EI;
        end else begin
          ctl.cop0_src = signals_pkg::C0_SRC_STATUS_DI;
        end
        ctl.dest_cop0  = signals_pkg::DEST_C0_STATUS;
        ctl.write_cop0 = 1'b1;
        ctl.reg_src    = signals_pkg::REG_SRC_COP0; // old status lands in rt
        ctl.reg_dest   = signals_pkg::REG_DEST_RT;
        ctl.write_reg  = 1'b1;
      end

      default: begin
        if ((f.rs & signals_pkg::RS_CO) == signals_pkg::RS_CO &&
            f.funct == signals_pkg::FN_ERET) begin
          ctl.pc_src     = signals_pkg::PC_ERET;
          ctl.cop0_src   = signals_pkg::C0_SRC_STATUS_ERET;
          ctl.dest_cop0  = signals_pkg::DEST_C0_STATUS;
          ctl.write_cop0 = 1'b1;
        end else begin
          ctl = signals_pkg::reserved_control();
        end
      end
    endcase
  end

endmodule

// File: src/instr_decoder.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module instr_decoder (
  input  logic [`DEC_INSTR_W-1:0] instr,
  output signals_pkg::control_t   ctl
);

  signals_pkg::unpack_t  f;
  signals_pkg::control_t c0_ctl;

  cop0_decoder i_cop0_decoder (
    .instr (instr),
    .ctl   (c0_ctl)
  );

  assign f = signals_pkg::unpack(instr);

  always_comb begin
    ctl = signals_pkg::default_control();
    case (f.op)
      signals_pkg::OP_SPECIAL: begin
        ctl.opd_use   = signals_pkg::OPD_RS_RT;
        ctl.reg_src   = signals_pkg::REG_SRC_ALU;
        ctl.reg_dest  = signals_pkg::REG_DEST_RD;
        ctl.write_reg = 1'b1;
        case (f.funct)
          signals_pkg::FN_ADDU: ctl.alu_op = signals_pkg::ALU_ADD;
          signals_pkg::FN_SUBU: ctl.alu_op = signals_pkg::ALU_SUB;
          signals_pkg::FN_AND:  ctl.alu_op = signals_pkg::ALU_AND;
          signals_pkg::FN_OR:   ctl.alu_op = signals_pkg::ALU_OR;
          signals_pkg::FN_SLT:  ctl.alu_op = signals_pkg::ALU_SLT;
          signals_pkg::FN_JR: begin
            ctl.opd_use   = signals_pkg::OPD_RS;
            ctl.pc_src    = signals_pkg::PC_JR;
            ctl.write_reg = 1'b0;
          end
          default: ctl = signals_pkg::reserved_control();
        endcase
      end

      signals_pkg::OP_ADDIU: begin
        ctl.opd_use    = signals_pkg::OPD_RS;
        ctl.alu_op     = signals_pkg::ALU_ADD;
        ctl.reg_dest   = signals_pkg::REG_DEST_RT;
        ctl.write_reg  = 1'b1;
        ctl.imm_signed = 1'b1;
      end

      signals_pkg::OP_ORI: begin
        ctl.opd_use   = signals_pkg::OPD_RS;
        ctl.alu_op    = signals_pkg::ALU_OR;
        ctl.reg_dest  = signals_pkg::REG_DEST_RT;
        ctl.write_reg = 1'b1; // zero-extended immediate
      end

      signals_pkg::OP_LUI: begin
        ctl.reg_src   = signals_pkg::REG_SRC_IMM_UPPER;
        ctl.reg_dest  = signals_pkg::REG_DEST_RT;
        ctl.write_reg = 1'b1;
      end

      signals_pkg::OP_BEQ: begin
        ctl.opd_use    = signals_pkg::OPD_RS_RT;
        ctl.alu_op     = signals_pkg::ALU_SUB; // compare rs and rt
        ctl.pc_src     = signals_pkg::PC_BRANCH;
        ctl.imm_signed = 1'b1;
      end

      signals_pkg::OP_J: ctl.pc_src = signals_pkg::PC_JUMP;

      signals_pkg::OP_COP0: ctl = c0_ctl;

      default: ctl = signals_pkg::reserved_control();
    endcase
  end

endmodule

// File: src/decode_ctrl.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module decode_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_req,
  output logic                    in_ack,
  input  logic [`DEC_INSTR_W-1:0] instr,
  output logic [`DEC_INSTR_W-1:0] instr_q,
  input  signals_pkg::control_t   dec_ctl,
  output logic                    out_req,
  input  logic                    out_ack,
  output signals_pkg::control_t   ctl
);

  typedef enum logic [1:0] {IDLE, IN_RELEASE, OUT_HOLD, OUT_RELEASE} state_e;

  state_e state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      ctl   <= signals_pkg::default_control();
    end else begin
      case (state)
        IDLE:        if (in_req) state <= IN_RELEASE;
        IN_RELEASE: begin
          if (!in_req) begin
            ctl   <= dec_ctl; // decode settled from instr_q
            state <= OUT_HOLD;
          end
        end
        OUT_HOLD:    if (out_ack) state <= OUT_RELEASE;
        OUT_RELEASE: if (!out_ack) state <= IDLE;
        default:     state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && in_req) instr_q <= instr;
  end

  assign in_ack  = (state == IN_RELEASE);
  assign out_req = (state == OUT_HOLD);

  // result must wait for the consumer
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_req && !out_ack |=> out_req && $stable(ctl));

  a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(in_ack) |-> $past(in_req));

endmodule

// File: src/decode_top.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module decode_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_req,
  output logic                    in_ack,
  input  logic [`DEC_INSTR_W-1:0] instr,
  output logic                    out_req,
  input  logic                    out_ack,
  output signals_pkg::control_t   ctl
);

  logic [`DEC_INSTR_W-1:0] instr_q;
  signals_pkg::control_t   dec_ctl;

  decode_ctrl i_decode_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .instr   (instr),
    .instr_q (instr_q),
    .dec_ctl (dec_ctl),
    .out_req (out_req),
    .out_ack (out_ack),
    .ctl     (ctl)
  );

  instr_decoder i_instr_decoder (
    .instr (instr_q),
    .ctl   (dec_ctl)
  );

endmodule

// File: tb/decode_checker.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module decode_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_ack,
  input  logic                  out_req,
  input  signals_pkg::control_t ctl,
  output int                    n_results,
  output int                    n_errors
);

  logic [`DEC_INSTR_W-1:0] pending_q[$];
  signals_pkg::control_t   held_ctl;
  logic                    out_req_d;
  logic                    reset_checked;

  task automatic push_expected(input logic [`DEC_INSTR_W-1:0] x);
    pending_q.push_back(x);
  endtask

  // every selector at its first code, nothing written
  function automatic signals_pkg::control_t idle_word();
    signals_pkg::control_t c;
    c = '0;
    return c;
  endfunction

  function automatic signals_pkg::control_t ref_decode(input logic [`DEC_INSTR_W-1:0] x);
    signals_pkg::control_t c;
    logic [5:0]            op;
    logic [5:0]            fn;
    logic [4:0]            rs;
    logic                  bad;
    c   = idle_word();
    op  = x[31:26];
    rs  = x[25:21];
    fn  = x[5:0];
    bad = 1'b0;
    if (op == 6'h00 && fn == 6'h08) begin // jr
      c.opd_use = signals_pkg::OPD_RS;
      c.pc_src  = signals_pkg::PC_JR;
    end else if (op == 6'h00) begin
      c.opd_use   = signals_pkg::OPD_RS_RT;
      c.write_reg = 1'b1;
      if (fn == 6'h21) c.alu_op = signals_pkg::ALU_ADD;
      else if (fn == 6'h23) c.alu_op = signals_pkg::ALU_SUB;
      else if (fn == 6'h24) c.alu_op = signals_pkg::ALU_AND;
      else if (fn == 6'h25) c.alu_op = signals_pkg::ALU_OR;
      else if (fn == 6'h2a) c.alu_op = signals_pkg::ALU_SLT;
      else bad = 1'b1;
    end else if (op == 6'h09 || op == 6'h0d) begin // addiu, ori
      c.opd_use    = signals_pkg::OPD_RS;
      c.reg_dest   = signals_pkg::REG_DEST_RT;
      c.write_reg  = 1'b1;
      c.imm_signed = (op == 6'h09);
      if (op == 6'h0d) c.alu_op = signals_pkg::ALU_OR;
    end else if (op == 6'h0f) begin
      c.reg_src   = signals_pkg::REG_SRC_IMM_UPPER;
      c.reg_dest  = signals_pkg::REG_DEST_RT;
      c.write_reg = 1'b1;
    end else if (op == 6'h04) begin
      c.opd_use    = signals_pkg::OPD_RS_RT;
      c.alu_op     = signals_pkg::ALU_SUB;
      c.pc_src     = signals_pkg::PC_BRANCH;
      c.imm_signed = 1'b1;
    end else if (op == 6'h02) begin
      c.pc_src = signals_pkg::PC_JUMP;
    end else if (op == 6'h10 && rs == 5'h04) begin // mtc0
      c.opd_use    = signals_pkg::OPD_RT;
      c.dest_cop0  = signals_pkg::DEST_C0_RDSEL;
      c.write_cop0 = 1'b1;
      c.cop0_sel   = x[15:11];
    end else if (op == 6'h10 && rs == 5'h00) begin // mfc0
      c.reg_src   = signals_pkg::REG_SRC_COP0;
      c.reg_dest  = signals_pkg::REG_DEST_RT;
      c.write_reg = 1'b1;
      c.cop0_sel  = x[15:11];
    end else if (op == 6'h10 && rs == 5'h0b) begin // ei / di
      c.cop0_src = x[5] ? signals_pkg::C0_SRC_STATUS_EI : signals_pkg::C0_SRC_STATUS_DI;
      c.dest_cop0  = signals_pkg::DEST_C0_STATUS;
      c.write_cop0 = 1'b1;
      c.reg_src    = signals_pkg::REG_SRC_COP0;
      c.reg_dest   = signals_pkg::REG_DEST_RT;
      c.write_reg  = 1'b1;
    end else if (op == 6'h10 && rs[4] && fn == 6'h18) begin // eret
      c.pc_src     = signals_pkg::PC_ERET;
      c.cop0_src   = signals_pkg::C0_SRC_STATUS_ERET;
      c.dest_cop0  = signals_pkg::DEST_C0_STATUS;
      c.write_cop0 = 1'b1;
    end else begin
      bad = 1'b1;
    end
    if (bad) begin
      c         = idle_word();
      c.pc_src  = signals_pkg::PC_EXCEPTION;
      c.exc_chk = signals_pkg::EXC_RESERVED;
    end
    return c;
  endfunction

  task automatic compare_result();
    logic [`DEC_INSTR_W-1:0] x;
    signals_pkg::control_t   exp_ctl;
    held_ctl = ctl;
    if (pending_q.size() == 0) begin
      $display("result %h appeared at %0t ns with no instruction pending", ctl, $time);
      n_errors++;
    end else begin
      x       = pending_q.pop_front();
      exp_ctl = ref_decode(x);
      n_results++;
      if (ctl !== exp_ctl) begin
        $display("Error: %0t ns instr %h expected %h got %h", $time, x, exp_ctl, ctl);
        n_errors++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      n_results     = 0;
      n_errors      = 0;
      out_req_d     = 1'b0;
      reset_checked = 1'b0;
    end else begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (in_ack !== 1'b0 || out_req !== 1'b0 || ctl !== idle_word()) begin
          $display("Error: %0t ns after reset in_ack %b out_req %b ctl %h",
                   $time, in_ack, out_req, ctl);
          n_errors++;
        end
      end
      if (out_req && !out_req_d) begin
        compare_result();
      end else if (out_req && ctl !== held_ctl) begin
        $display("Error: %0t ns ctl changed from %h to %h while out_req high",
                 $time, held_ctl, ctl);
        n_errors++;
      end
      out_req_d = out_req;
    end
  end

endmodule

// File: tb/decode_tb.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module decode_tb;

  localparam int N_DIRECTED   = 20;
  localparam int N_RANDOM     = 200;
  localparam int LIMIT_CYCLES = (N_DIRECTED + N_RANDOM) * 40;

  logic                    clk     = 1'b0;
  logic                    rst_n   = 1'b0;
  logic                    in_req  = 1'b0;
  logic                    out_ack = 1'b0;
  logic [`DEC_INSTR_W-1:0] instr   = '0;
  logic                    in_ack;
  logic                    out_req;
  signals_pkg::control_t   ctl;
  int                      n_results;
  int                      n_errors;
  int                      n_sent;
  logic [31:0]             prod_state;
  logic [31:0]             cons_state;

  // alu and immediate, then beq j jr, then cop0, then reserved encodings
  logic [31:0] directed [N_DIRECTED] = '{
    32'h00221821, 32'h00221823, 32'h00221824, 32'h00221825,
    32'h0022182a, 32'h2422fffc, 32'h342200f0, 32'h3c021234,
    32'h10220004, 32'h08000100, 32'h03e00008,
    32'h40826000, 32'h40036800, 32'h41646020, 32'h41646000, 32'h42000018,
    32'hfc000000, 32'h0022183f, 32'h40200000, 32'h42000001
  };

  decode_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .instr   (instr),
    .out_req (out_req),
    .out_ack (out_ack),
    .ctl     (ctl)
  );

  decode_checker i_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ack    (in_ack),
    .out_req   (out_req),
    .ctl       (ctl),
    .n_results (n_results),
    .n_errors  (n_errors)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // mostly legal opcodes, with some bad functs and rs codes mixed in
  function automatic logic [31:0] random_instr(input logic [31:0] r);
    logic [47:0] ops;
    logic [47:0] fns;
    logic [39:0] rss;
    logic [31:0] x;
    ops = {6'h00, 6'h09, 6'h0d, 6'h0f, 6'h04, 6'h02, 6'h10, 6'h10};
    fns = {6'h21, 6'h23, 6'h24, 6'h25, 6'h2a, 6'h08, 6'h3f, 6'h18};
    rss = {5'h00, 5'h04, 5'h0b, 5'h0b, 5'h10, 5'h1f, 5'h01, 5'h10};
    x = lcg(r);
    x[31:26] = ops[r[31:29]*6 +: 6];
    if (x[31:26] == 6'h00) x[5:0] = fns[r[28:26]*6 +: 6];
    if (x[31:26] == 6'h10) begin
      x[25:21] = rss[r[25:23]*5 +: 5];
      if (r[22]) x[5:0] = 6'h18;
    end
    return x;
  endfunction

  task automatic send_instr(input logic [31:0] x);
    @(negedge clk);
    instr  = x;
    in_req = 1'b1;
    do @(negedge clk); while (!in_ack);
    in_req = 1'b0;
    i_checker.push_expected(x);
    do @(negedge clk); while (in_ack);
    n_sent++;
  endtask

  task automatic run_directed(input string name, input int first, input int last);
    int err_before;
    err_before = n_errors;
    for (int i = first; i <= last; i++) send_instr(directed[i]);
    wait (n_results == n_sent);
    $display("test %s done, %0d errors", name, n_errors - err_before);
  endtask

  // consumer side with a random ack delay
  always @(negedge clk) begin
    if (rst_n && out_req && !out_ack) begin
      cons_state = lcg(cons_state);
      repeat (cons_state[30:28]) @(negedge clk);
      out_ack = 1'b1;
      do @(negedge clk); while (out_req);
      out_ack = 1'b0;
    end
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("timeout: the handshake stalled after %0d of %0d results", n_results, n_sent);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int err_before;
    n_sent     = 0;
    prod_state = 32'he4c54511;
    cons_state = lcg(32'he4c54511);
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    $display("test reset done, %0d errors", n_errors);
    run_directed("alu_imm", 0, 7);
    run_directed("branch", 8, 10);
    run_directed("cop0", 11, 15);
    run_directed("reserved", 16, 19);
    err_before = n_errors;
    for (int i = 0; i < N_RANDOM; i++) begin
      prod_state = lcg(prod_state);
      send_instr(random_instr(prod_state));
    end
    wait (n_results == n_sent);
    $display("test random done, %0d errors", n_errors - err_before);
    $display("%0d results for %0d instructions, %0d errors", n_results, n_sent, n_errors);
    if (n_errors == 0 && n_results == n_sent) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+src
src/signals_pkg.sv
src/cop0_decoder.sv
src/instr_decoder.sv
src/decode_ctrl.sv
src/decode_top.sv
tb/decode_checker.sv
tb/decode_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing
TOP       := decode_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
